/* hw/motor_pkg.sv */
package motor_pkg;

  // ====================
  // channel sizes
  // ====================
  localparam int N_MOTORS   = 8;
  localparam int IDX_W      = $clog2(N_MOTORS);   // channel select bits
  localparam int CNT_W      = 32;                 // signed encoder count
  localparam int DUTY_W     = 12;
  localparam int PWM_PERIOD = 2 ** DUTY_W;        // clocks per pwm frame

  // clock and led rate
  localparam int CLK_HZ     = 50_000_000;
  localparam int BLINK_HZ   = 10;
  localparam int BLINK_HALF = CLK_HZ / (2 * BLINK_HZ);  // clocks per led phase
  localparam int BLINK_W    = $clog2(BLINK_HALF);

  // ====================
  // register map
  // ====================
  localparam int ADDR_W = 5;
  localparam int DATA_W = 32;

  localparam logic [ADDR_W-1:0] REG_PWM_BASE = ADDR_W'(0);   // 0..7
  localparam logic [ADDR_W-1:0] REG_CNT_BASE = ADDR_W'(8);   // 8..15
  localparam logic [ADDR_W-1:0] REG_RST_MASK = ADDR_W'(16);
  localparam logic [ADDR_W-1:0] REG_STATUS   = ADDR_W'(17);

  // status word layout
  localparam int STAT_ESTOP_BIT = 0;   // e-stop pin level
  localparam int STAT_FAULT_LSB = 8;   // fault pins, one per channel

  // one channel command, low 14 bits of a pwm register
  typedef struct packed {
    logic              enable;   // driver enable
    logic              dir;      // motor direction
    logic [DUTY_W-1:0] duty;     // high clocks per frame
  } pwm_cmd_t;

  // host request payload, held stable while req is high
  typedef struct packed {
    logic              we;       // 1 write, 0 read
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } host_req_t;

endpackage

/* hw/quad_decoder.sv */
`timescale 1ns/10ps

module quad_decoder (
  input  logic                               i_fpga_clk_50,
  input  logic                               i_rst_n,
  input  logic                               i_clear,   // hold count at zero
  input  logic                               i_enc_a,
  input  logic                               i_enc_b,
  output logic signed [motor_pkg::CNT_W-1:0] o_count
);

  logic [1:0] a_sync;   // [1] is the settled stage
  logic [1:0] b_sync;
  logic       a_prev;   // last settled state
  logic       b_prev;
  logic       step;     // exactly one line moved
  logic       up;       // a leads b

  // ====================
  // input synchronizers
  // ====================
  always_ff @(posedge i_fpga_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      a_sync <= '0;
      b_sync <= '0;
    end else begin
      a_sync <= {a_sync[0], i_enc_a};
      b_sync <= {b_sync[0], i_enc_b};
    end
  end

  // gray step check, both lines moving is a lost edge and counts nothing
  assign step = (a_sync[1] ^ a_prev) ^ (b_sync[1] ^ b_prev);
  assign up   = a_sync[1] ^ b_prev;   // 00>10>11>01 is forward

  // ====================
  // x4 counter
  // ====================
  always_ff @(posedge i_fpga_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      a_prev  <= 1'b0;
      b_prev  <= 1'b0;
      o_count <= '0;
    end else begin
      a_prev <= a_sync[1];   // keep tracking while cleared
      b_prev <= b_sync[1];
      if (i_clear) begin
        o_count <= '0;
      end else if (step) begin
        o_count <= up ? o_count + 1 : o_count - 1;   // wraps two's complement
      end
    end
  end

endmodule

/* hw/pwm_gen.sv */
`timescale 1ns/10ps

module pwm_gen (
  input  logic                i_fpga_clk_50,
  input  logic                i_rst_n,
  input  motor_pkg::pwm_cmd_t i_cmd,      // live register value
  output logic                o_pwm,
  output logic                o_dir,
  output logic                o_enable
);

  import motor_pkg::*;

  logic [DUTY_W-1:0] period_cnt;   // free running frame position
  logic              wrap;         // last clock of the frame
  pwm_cmd_t          shadow;       // command for the current frame

  assign wrap = (period_cnt == DUTY_W'(PWM_PERIOD - 1));

  // ====================
  // frame counter
  // ====================
  always_ff @(posedge i_fpga_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      period_cnt <= '0;
      shadow     <= '0;   // driver off until first frame load
    end else begin
      period_cnt <= period_cnt + 1'b1;   // rolls over to zero after wrap
      if (wrap) begin
        shadow <= i_cmd;   // new duty only at frame start, no short pulses
      end
    end
  end

  // high for duty clocks from frame start
  assign o_pwm    = shadow.enable && (period_cnt < shadow.duty);
  assign o_dir    = shadow.dir;
  assign o_enable = shadow.enable;   // e-stop gating happens at the top

endmodule

/* hw/blink_divider.sv */
`timescale 1ns/10ps

module blink_divider (
  input  logic i_fpga_clk_50,
  input  logic i_rst_n,
  output logic o_led          // activity blink
);

  import motor_pkg::*;

  logic [BLINK_W-1:0] div_cnt;    // clocks into this led phase
  logic               terminal;   // last clock of a phase

  assign terminal = (div_cnt == BLINK_W'(BLINK_HALF - 1));

  // ====================
  // divider
  // ====================
  always_ff @(posedge i_fpga_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      div_cnt <= '0;
      o_led   <= 1'b0;   // off out of reset
    end else if (terminal) begin
      div_cnt <= '0;
      o_led   <= ~o_led;   // half period done
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

/* hw/host_regs.sv */
`timescale 1ns/10ps

module host_regs (
  input  logic                               i_fpga_clk_50,
  input  logic                               i_rst_n,
  input  logic                               i_host_req,
  input  motor_pkg::host_req_t               i_host_pkt,
  output logic                               o_host_ack,
  output logic [motor_pkg::DATA_W-1:0]       o_host_rdata,
  input  logic signed [motor_pkg::CNT_W-1:0] i_counts [motor_pkg::N_MOTORS],
  input  logic                               i_nestop,
  input  logic [motor_pkg::N_MOTORS-1:0]     i_nfault,
  output motor_pkg::pwm_cmd_t                o_cmds [motor_pkg::N_MOTORS],
  output logic [motor_pkg::N_MOTORS-1:0]     o_clear   // encoder reset mask
);

  import motor_pkg::*;

  logic              start;      // req seen high, ack still low
  logic [ADDR_W-1:0] pwm_off;    // offset into pwm block
  logic [ADDR_W-1:0] cnt_off;    // offset into count block
  logic              pwm_hit;
  logic              cnt_hit;
  logic              mask_hit;
  logic              stat_hit;
  logic [DATA_W-1:0] status;
  logic [DATA_W-1:0] rd_mux;

  // one access per transaction, ack high blocks a repeat
  assign start = i_host_req && !o_host_ack;

  // ====================
  // address decode
  // ====================
  always_comb begin
    pwm_off  = i_host_pkt.addr - REG_PWM_BASE;
    cnt_off  = i_host_pkt.addr - REG_CNT_BASE;   // wraps high below the block
    pwm_hit  = (pwm_off < ADDR_W'(N_MOTORS));
    cnt_hit  = (cnt_off < ADDR_W'(N_MOTORS));
    mask_hit = (i_host_pkt.addr == REG_RST_MASK);
    stat_hit = (i_host_pkt.addr == REG_STATUS);
  end

  always_comb begin
    status                               = '0;
    status[STAT_ESTOP_BIT]               = i_nestop;
    status[STAT_FAULT_LSB +: N_MOTORS]   = i_nfault;   // raw active-low levels
  end

  // read data, unmapped gives zero
  always_comb begin
    rd_mux = '0;
    if (pwm_hit) begin
      rd_mux = DATA_W'(o_cmds[pwm_off[IDX_W-1:0]]);
    end else if (cnt_hit) begin
      rd_mux = DATA_W'(i_counts[cnt_off[IDX_W-1:0]]);
    end else if (mask_hit) begin
      rd_mux = DATA_W'(o_clear);
    end else if (stat_hit) begin
      rd_mux = status;
    end
  end

  // ====================
  // handshake and storage
  // ====================
  always_ff @(posedge i_fpga_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_host_ack <= 1'b0;
      o_clear    <= '0;
      for (int i = 0; i < N_MOTORS; i++) begin
        o_cmds[i] <= '0;
      end
    end else begin
      if (start) begin
        o_host_ack <= 1'b1;
      end else if (!i_host_req) begin
        o_host_ack <= 1'b0;   // req dropped, close the transaction
      end
      if (start && i_host_pkt.we) begin   // writes to counts or status are dropped
        if (pwm_hit) begin
          o_cmds[pwm_off[IDX_W-1:0]] <= pwm_cmd_t'(i_host_pkt.wdata[$bits(pwm_cmd_t)-1:0]);
        end else if (mask_hit) begin
          o_clear <= i_host_pkt.wdata[N_MOTORS-1:0];
        end
      end
    end
  end

  // captured at start, held while ack is high
  always_ff @(posedge i_fpga_clk_50) begin
    if (start) begin
      o_host_rdata <= rd_mux;
    end
  end

endmodule

/* hw/motor_ctrl_top.sv */
`timescale 1ns/10ps

module motor_ctrl_top (
  input  logic                           i_fpga_clk_50,
  input  logic                           i_rst_n,
  // host register port
  input  logic                           i_host_req,
  input  motor_pkg::host_req_t           i_host_pkt,
  output logic                           o_host_ack,
  output logic [motor_pkg::DATA_W-1:0]   o_host_rdata,
  // motor channel pins
  input  logic [motor_pkg::N_MOTORS-1:0] i_enc_a,
  input  logic [motor_pkg::N_MOTORS-1:0] i_enc_b,
  input  logic [motor_pkg::N_MOTORS-1:0] i_nfault,
  input  logic                           i_nestop,     // low stops all drivers
  output logic [motor_pkg::N_MOTORS-1:0] o_pwm,
  output logic [motor_pkg::N_MOTORS-1:0] o_dir,
  output logic [motor_pkg::N_MOTORS-1:0] o_en_reset,
  output logic                           o_act_led
);

  import motor_pkg::*;

  logic signed [CNT_W-1:0] counts [N_MOTORS];   // decoder to regs
  pwm_cmd_t                cmds   [N_MOTORS];   // regs to pwm
  logic [N_MOTORS-1:0]     clear;               // per channel count clear
  logic [N_MOTORS-1:0]     drv_en;              // enable before e-stop

  // ====================
  // register port
  // ====================
  host_regs u_regs (
    .i_fpga_clk_50 (i_fpga_clk_50),
    .i_rst_n       (i_rst_n),
    .i_host_req    (i_host_req),
    .i_host_pkt    (i_host_pkt),
    .o_host_ack    (o_host_ack),
    .o_host_rdata  (o_host_rdata),
    .i_counts      (counts),
    .i_nestop      (i_nestop),
    .i_nfault      (i_nfault),
    .o_cmds        (cmds),
    .o_clear       (clear)
  );

  // ====================
  // motor channels
  // ====================
  for (genvar i = 0; i < N_MOTORS; i++) begin : g_ch
    quad_decoder u_quad (
      .i_fpga_clk_50 (i_fpga_clk_50),
      .i_rst_n       (i_rst_n),
      .i_clear       (clear[i]),
      .i_enc_a       (i_enc_a[i]),
      .i_enc_b       (i_enc_b[i]),
      .o_count       (counts[i])
    );

    pwm_gen u_pwm (
      .i_fpga_clk_50 (i_fpga_clk_50),
      .i_rst_n       (i_rst_n),
      .i_cmd         (cmds[i]),
      .o_pwm         (o_pwm[i]),
      .o_dir         (o_dir[i]),
      .o_enable      (drv_en[i])
    );

    assign o_en_reset[i] = drv_en[i] & i_nestop;   // e-stop overrides, no clock
  end

  blink_divider u_blink (
    .i_fpga_clk_50 (i_fpga_clk_50),
    .i_rst_n       (i_rst_n),
    .o_led         (o_act_led)
  );

endmodule

/* verif/motor_ctrl_chk.sv */
`timescale 1ns/10ps

module motor_ctrl_chk (
  input logic                           i_fpga_clk_50,
  input logic                           i_rst_n,
  input logic                           i_host_req,
  input logic                           i_host_ack,
  input logic                           i_nestop,
  input logic [motor_pkg::N_MOTORS-1:0] i_en_reset
);

  int fail_cnt = 0;   // assertion failure tally

  // ====================
  // host handshake
  // ====================
  ack_needs_req : assert property (@(posedge i_fpga_clk_50) disable iff (!i_rst_n)
    $rose(i_host_ack) |-> $past(i_host_req)
  ) else begin
    fail_cnt++;
    $error("host ack rose without req");
  end

  // ack holds until req drops
  ack_holds : assert property (@(posedge i_fpga_clk_50) disable iff (!i_rst_n)
    $fell(i_host_ack) |-> $past(!i_host_req)
  ) else begin
    fail_cnt++;
    $error("host ack fell while req was high");
  end

  // ====================
  // e-stop
  // ====================
  estop_gates : assert property (@(posedge i_fpga_clk_50)
    !i_nestop |-> (i_en_reset == '0)
  ) else begin
    fail_cnt++;
    $error("driver enable high during e-stop");
  end

endmodule

/* verif/tb_motor_ctrl.sv */
`timescale 1ns/10ps

module tb_motor_ctrl;

  import motor_pkg::*;

  localparam int HS_LIMIT  = 16;   // handshake wait in clocks
  localparam int STEP_HOLD = 4;    // clocks per encoder state past the sync delay

  logic                i_fpga_clk_50;
  logic                i_rst_n;
  logic                i_host_req;
  host_req_t           i_host_pkt;
  logic                o_host_ack;
  logic [DATA_W-1:0]   o_host_rdata;
  logic [N_MOTORS-1:0] i_enc_a;
  logic [N_MOTORS-1:0] i_enc_b;
  logic [N_MOTORS-1:0] i_nfault;
  logic                i_nestop;
  logic [N_MOTORS-1:0] o_pwm;
  logic [N_MOTORS-1:0] o_dir;
  logic [N_MOTORS-1:0] o_en_reset;
  logic                o_act_led;

  int n_checks = 0;
  int n_errors = 0;
  int phase [N_MOTORS] = '{default: 0};   // gray position per encoder

  motor_ctrl_top UUT (.*);

  bind motor_ctrl_top motor_ctrl_chk u_chk (
    .i_fpga_clk_50 (i_fpga_clk_50),
    .i_rst_n       (i_rst_n),
    .i_host_req    (i_host_req),
    .i_host_ack    (o_host_ack),
    .i_nestop      (i_nestop),
    .i_en_reset    (o_en_reset)
  );

  initial begin
    i_fpga_clk_50 = 1'b0;
    forever #10 i_fpga_clk_50 = ~i_fpga_clk_50;   // 50 MHz
  end

  // ====================
  // helpers
  // ====================
  task automatic tick();   // drive and sample point 2 ns after the edge
    @(posedge i_fpga_clk_50);
    #2;
  endtask

  task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("ERROR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report_bad_line(input string line);
    n_errors++;
    $display("stimulus line has missing or unreadable fields: %s", line);
  endtask

  // forward order 00 10 11 01 with a leading b
  function automatic logic [1:0] gray_ab(input int ph);
    case (ph)
      0:       return 2'b00;
      1:       return 2'b10;
      2:       return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  // one four-phase transaction
  task automatic host_access(input logic we, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int n;
    i_host_pkt = {we, addr, wdata};
    i_host_req = 1'b1;
    n = 0;
    tick();
    while (!o_host_ack && n < HS_LIMIT) begin
      tick();
      n++;
    end
    if (!o_host_ack) begin
      n_errors++;
      $display("host ack never rose for address %h", addr);
    end
    rdata      = o_host_rdata;   // valid while ack is high
    i_host_req = 1'b0;
    n = 0;
    tick();
    while (o_host_ack && n < HS_LIMIT) begin
      tick();
      n++;
    end
    if (o_host_ack) begin
      n_errors++;
      $display("host ack stayed high after req dropped, address %h", addr);
    end
    i_host_pkt = '0;
  endtask

  task automatic step_encoder(input int ch, input int steps);
    int n_abs;
    n_abs = (steps < 0) ? -steps : steps;
    for (int i = 0; i < n_abs; i++) begin
      phase[ch] = (phase[ch] + ((steps < 0) ? 3 : 1)) % 4;   // 3 is one step back
      {i_enc_a[ch], i_enc_b[ch]} = gray_ab(phase[ch]);
      repeat (STEP_HOLD) tick();
    end
  endtask

  task automatic measure_pwm(input int ch, input int exp_high, input int exp_dir);
    int   n;
    int   high;
    logic prev;
    repeat (PWM_PERIOD) tick();   // at least one frame start since the write
    if (exp_high != 0) begin
      n    = 0;
      prev = o_pwm[ch];
      tick();
      while (!(o_pwm[ch] && !prev) && n < 2 * PWM_PERIOD) begin   // rise = frame start
        prev = o_pwm[ch];
        tick();
        n++;
      end
      if (!(o_pwm[ch] && !prev)) begin
        n_errors++;
        $display("no pwm rising edge on channel %0d", ch);
      end
    end
    high = 0;
    for (int k = 0; k < PWM_PERIOD; k++) begin
      high += o_pwm[ch];
      tick();
    end
    check_val($sformatf("pwm high ch%0d", ch), exp_high, high);
    check_val($sformatf("pwm dir ch%0d", ch), exp_dir, o_dir[ch]);
  endtask

  task automatic set_estop(input logic level, input logic [N_MOTORS-1:0] exp_en);
    i_nestop = level;
    #1;   // gating is combinational
    check_val($sformatf("estop %0d", level), exp_en, o_en_reset);
    tick();
  endtask

  // ====================
  // file driven sequence
  // ====================
  task automatic run_file();
    int                fd;
    string             line;
    logic [31:0]       x;
    logic [31:0]       y;
    int                a;
    int                b;
    int                c;
    int                cnt;
    logic [DATA_W-1:0] rdata;
    fd = $fopen("verif/motor_input.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("could not open verif/motor_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;   // blank or column notes
      case (line[0])
        "W": begin
          cnt = $sscanf(line, "W %h %h", x, y);
          if (cnt != 2) begin
            report_bad_line(line);
          end else begin
            host_access(1'b1, x[ADDR_W-1:0], y, rdata);
          end
        end
        "R": begin
          cnt = $sscanf(line, "R %h %h", x, y);
          if (cnt != 2) begin
            report_bad_line(line);
          end else begin
            host_access(1'b0, x[ADDR_W-1:0], '0, rdata);
            check_val($sformatf("read %02h", x[ADDR_W-1:0]), y, rdata);
          end
        end
        "Q": begin
          cnt = $sscanf(line, "Q %d %d", a, b);
          if (cnt != 2) begin
            report_bad_line(line);
          end else begin
            step_encoder(a, b);
          end
        end
        "E": begin
          cnt = $sscanf(line, "E %h %h", x, y);
          if (cnt != 2) begin
            report_bad_line(line);
          end else begin
            set_estop(x[0], y[N_MOTORS-1:0]);
          end
        end
        "P": begin
          cnt = $sscanf(line, "P %d %d %d", a, b, c);
          if (cnt != 3) begin
            report_bad_line(line);
          end else begin
            measure_pwm(a, b, c);
          end
        end
        default: begin
          n_errors++;
          $display("unknown operation in stimulus line %s", line);
        end
      endcase
    end
    $fclose(fd);
  endtask

  // led phases counted in edges from reset release
  task automatic check_led();
    int n;
    check_val("led after reset", 0, o_act_led);
    n = 0;
    while (!o_act_led && n <= BLINK_HALF + 4) begin
      tick();
      n++;
    end
    check_val("led rise", BLINK_HALF, n);
    n = 0;
    while (o_act_led && n <= BLINK_HALF + 4) begin
      tick();
      n++;
    end
    check_val("led fall", BLINK_HALF, n);
  endtask

  initial begin
    i_rst_n    = 1'b0;
    i_host_req = 1'b0;
    i_host_pkt = '0;
    i_enc_a    = '0;
    i_enc_b    = '0;
    i_nfault   = 8'hc3;   // fixed fault pattern for status bits 15:8
    i_nestop   = 1'b1;
    repeat (4) tick();
    i_rst_n = 1'b1;
    fork
      run_file();
      check_led();
    join
    n_errors += UUT.u_chk.fail_cnt;
    $display("checks %0d errors %0d assertion failures %0d",
             n_checks, n_errors, UUT.u_chk.fail_cnt);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* verif/motor_input.txt */
# op W addr data, R addr expected, E nestop expected en_reset (all hex)
# op Q channel signed gray steps, P channel high clocks dir (all decimal)
W 00 00002123
W 01 00003040
W 02 00001fff
W 07 00000800
R 00 00002123
R 01 00003040
R 02 00001fff
R 07 00000800
R 12 00000000
R 1f 00000000
W 08 12345678
R 08 00000000
Q 2 5
Q 3 -3
R 0a 00000005
R 0b fffffffd
R 0c 00000000
W 10 00000004
R 0a 00000000
R 10 00000004
W 10 00000000
Q 2 2
R 0a 00000002
P 0 291 0
P 1 64 1
P 2 0 1
E 1 03
R 11 0000c301
E 0 00
R 11 0000c300
E 1 03

/* sources.f */
hw/motor_pkg.sv
hw/quad_decoder.sv
hw/pwm_gen.sv
hw/blink_divider.sv
hw/host_regs.sv
hw/motor_ctrl_top.sv
verif/motor_ctrl_chk.sv
verif/tb_motor_ctrl.sv

/* Bender.yml */
package:
  name: motor_ctrl

sources:
  - hw/motor_pkg.sv
  - hw/quad_decoder.sv
  - hw/pwm_gen.sv
  - hw/blink_divider.sv
  - hw/host_regs.sv
  - hw/motor_ctrl_top.sv
  - target: test
    files:
      - verif/motor_ctrl_chk.sv
      - verif/tb_motor_ctrl.sv
